// ==== Makefile ====
# Verilator build and run for the event queue testbench

TOOL     ?= verilator
FLAGS    ?= --binary --timing --assert
TOP      ?= eventQueueTb
FILELIST ?= sources.f
LOG      ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

// ==== design/coalescingUnit.sv ====
// Per-lane coalescing unit
// Input stage, read-modify-write merge, one-deep pending write
// Pending sum is forwarded to a following event on the same vertex
`default_nettype none

module coalescingUnit
    import eventCfgPkg::*, eventIfPkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               rstN_i,
    input  wire logic               initialFinish_i,
    input  wire logic               binSelected_i,
    input  wire eventS              cuIn_i,
    output logic                    cuReady_o,
    output searchReqS               searchReq_o,
    input  wire logic [DELTA_W-1:0] searchValue_i,
    output logic                    cuClean_o
);

    eventS              inEvt;
    logic               accept;
    logic               fwdHit;
    logic [DELTA_W-1:0] baseValue;
    logic [DELTA_W-1:0] newValue;

    // Pending write toward the bin
    logic               pendValid;
    vertexAddrU         pendAddr;
    logic [DELTA_W-1:0] pendDelta;

    // Blocked only while our bin drains
    assign cuReady_o = ~binSelected_i;
    assign accept    = cuIn_i.valid & cuReady_o;

    // Input stage
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            inEvt.valid <= 1'b0;
        end else begin
            inEvt.valid <= accept;
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            inEvt.vertex <= cuIn_i.vertex;
            inEvt.delta  <= cuIn_i.delta;
        end
    end

    // Storage may still be stale, pending sum is newer
    assign fwdHit    = pendValid && (pendAddr.flat == inEvt.vertex.flat);
    assign baseValue = fwdHit ? pendDelta : searchValue_i;
    // Overwrite during the initial phase, accumulate afterwards
    assign newValue  = initialFinish_i ? DELTA_W'(baseValue + inEvt.delta) : inEvt.delta;

    // Pending write stage
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            pendValid <= 1'b0;
        end else begin
            pendValid <= inEvt.valid;
        end
    end

    always_ff @(posedge clk_i) begin
        if (inEvt.valid) begin
            pendAddr  <= inEvt.vertex;
            pendDelta <= newValue;
        end
    end

    always_comb begin
        searchReq_o.searchValid = inEvt.valid;
        searchReq_o.searchAddr  = inEvt.vertex;
        searchReq_o.wrValid     = pendValid;
        searchReq_o.wrAddr      = pendAddr;
        searchReq_o.wrDelta     = pendDelta;
    end

    // Nothing in flight, including a handshake this cycle
    assign cuClean_o = ~accept & ~inEvt.valid & ~pendValid;

endmodule

`default_nettype wire

// ==== design/eventBin.sv ====
// One bin of the event queues
// Delta storage, row occupancy bitmap, search port
// Row drain, lowest occupied row first
`default_nettype none

module eventBin
    import eventCfgPkg::*, eventIfPkg::*;
#(
    parameter int unsigned numRows = 8
) (
    input  wire logic               clk_i,
    input  wire logic               rstN_i,
    input  wire logic               binSelected_i,
    input  wire logic               readEn_i,
    input  wire searchReqS          searchReq_i,
    output logic [DELTA_W-1:0]      searchValue_o,
    output logic                    binValid_o,
    output rowS                     row_o,
    input  wire logic               rowReady_i
);

    // ========================================
    // Storage
    // ========================================
    logic [COL_NUM-1:0][DELTA_W-1:0] rowMem [numRows];
    // One bit per row, set by a write
    logic [numRows-1:0]              occupancy;

    logic [ROW_IDX_W-1:0]            drainRow;
    logic                            takeRow;

    // Search read, straight from the registers
    always_comb begin
        searchValue_o = '0;
        if (searchReq_i.searchValid) begin
            searchValue_o = rowMem[searchReq_i.searchAddr.fields.rowIdx]
                                  [searchReq_i.searchAddr.fields.colIdx];
        end
    end

    // Any occupied row makes the bin valid
    assign binValid_o = |occupancy;

    // ========================================
    // Drain side
    // ========================================
    // Lowest occupied row wins
    always_comb begin
        drainRow = '0;
        for (int r = numRows - 1; r >= 0; r--) begin
            if (occupancy[r]) begin
                drainRow = ROW_IDX_W'(r);
            end
        end
    end

    always_comb begin
        row_o        = '0;
        // Only offered while granted and enabled
        row_o.valid  = binSelected_i & readEn_i & binValid_o;
        row_o.rowIdx = drainRow;
        row_o.deltas = rowMem[drainRow];
    end

    // Handshake on the drain port
    assign takeRow = row_o.valid & rowReady_i;

    // ========================================
    // Update
    // ========================================
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            occupancy <= '0;
            for (int r = 0; r < numRows; r++) begin
                rowMem[r] <= '0;
            end
        end else begin
            // Taken row leaves as zeros
            if (takeRow) begin
                rowMem[drainRow]    <= '0;
                occupancy[drainRow] <= 1'b0;
            end
            // Merged delta from the coalescing unit
            if (searchReq_i.wrValid) begin
                rowMem[searchReq_i.wrAddr.fields.rowIdx][searchReq_i.wrAddr.fields.colIdx]
                    <= searchReq_i.wrDelta;
                occupancy[searchReq_i.wrAddr.fields.rowIdx] <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/eventCfgPkg.sv ====
// Geometry constants for bins, rows and columns
// Vertex address union, flat or decoded into bin/row/col
`default_nettype none

package eventCfgPkg;

    // Bins and input lanes are one to one
    localparam int BIN_NUM   = 4;
    localparam int COL_NUM   = 4;
    localparam int BIN_IDX_W = 2;
    localparam int ROW_IDX_W = 3;
    localparam int COL_IDX_W = 2;
    localparam int DELTA_W   = 16;
    // Bin in the MSBs, column in the LSBs
    localparam int VTX_W     = BIN_IDX_W + ROW_IDX_W + COL_IDX_W;

    typedef struct packed {
        logic [BIN_IDX_W-1:0] binIdx;
        logic [ROW_IDX_W-1:0] rowIdx;
        logic [COL_IDX_W-1:0] colIdx;
    } vertexFieldsS;

    typedef union packed {
        logic [VTX_W-1:0] flat;
        vertexFieldsS     fields;
    } vertexAddrU;

endpackage

`default_nettype wire

// ==== design/eventIfPkg.sv ====
// Packed structs crossing module boundaries
// Input events, drained rows, bin search and write requests
`default_nettype none

package eventIfPkg;

    import eventCfgPkg::*;

    // One (vertex, delta) event on a lane
    typedef struct packed {
        logic                 valid;
        vertexAddrU           vertex;
        logic [DELTA_W-1:0]   delta;
    } eventS;

    // One drained row of a bin
    typedef struct packed {
        logic                              valid;
        logic [BIN_IDX_W-1:0]              binIdx;
        logic [ROW_IDX_W-1:0]              rowIdx;
        logic [COL_NUM-1:0][DELTA_W-1:0]   deltas;
    } rowS;

    // Coalescing unit to bin, search port plus write port
    typedef struct packed {
        logic                 searchValid;
        vertexAddrU           searchAddr;
        logic                 wrValid;
        vertexAddrU           wrAddr;
        logic [DELTA_W-1:0]   wrDelta;
    } searchReqS;

endpackage

`default_nettype wire

// ==== design/eventQueueTop.sv ====
// Event queue subsystem top level
// Event queues plus the round-robin scheduler
`default_nettype none

module eventQueueTop
    import eventCfgPkg::*, eventIfPkg::*;
#(
    parameter int unsigned numRows = 8
) (
    input  wire logic                clk_i,
    input  wire logic                rstN_i,
    input  wire logic                initialFinish_i,
    input  wire logic                drainEn_i,
    input  wire eventS [BIN_NUM-1:0] cuIn_i,
    output logic [BIN_NUM-1:0]       cuReady_o,
    output rowS                      rowOut_o,
    input  wire logic                rowReady_i,
    output logic                     queueEmpty_o
);

    // Scheduler handshake
    logic [BIN_NUM-1:0] binValid;
    logic [BIN_NUM-1:0] cuClean;
    logic [BIN_NUM-1:0] binSelected;
    logic               readEn;

    eventQueues #(.numRows(numRows)) uQueues (
        .clk_i           (clk_i),
        .rstN_i          (rstN_i),
        .initialFinish_i (initialFinish_i),
        .cuIn_i          (cuIn_i),
        .cuReady_o       (cuReady_o),
        .cuClean_o       (cuClean),
        .binValid_o      (binValid),
        .binSelected_i   (binSelected),
        .readEn_i        (readEn),
        .rowOut_o        (rowOut_o),
        .rowReady_i      (rowReady_i),
        .queueEmpty_o    (queueEmpty_o)
    );

    queueScheduler uSched (
        .clk_i         (clk_i),
        .rstN_i        (rstN_i),
        .drainEn_i     (drainEn_i),
        .binValid_i    (binValid),
        .cuClean_i     (cuClean),
        .binSelected_o (binSelected),
        .readEn_o      (readEn)
    );

endmodule

`default_nettype wire

// ==== design/eventQueues.sv ====
// Event queues, one bin and one coalescing unit per lane
// Output row mux, drain ready steering, registered empty flag
`default_nettype none

module eventQueues
    import eventCfgPkg::*, eventIfPkg::*;
#(
    parameter int unsigned numRows = 8
) (
    input  wire logic                clk_i,
    input  wire logic                rstN_i,
    input  wire logic                initialFinish_i,
    input  wire eventS [BIN_NUM-1:0] cuIn_i,
    output logic [BIN_NUM-1:0]       cuReady_o,
    output logic [BIN_NUM-1:0]       cuClean_o,
    output logic [BIN_NUM-1:0]       binValid_o,
    input  wire logic [BIN_NUM-1:0]  binSelected_i,
    input  wire logic                readEn_i,
    output rowS                      rowOut_o,
    input  wire logic                rowReady_i,
    output logic                     queueEmpty_o
);

    searchReqS          searchReq   [BIN_NUM];
    logic [DELTA_W-1:0] searchValue [BIN_NUM];
    rowS                binRow      [BIN_NUM];
    logic [BIN_NUM-1:0] binReady;

    // ========================================
    // Per-lane slices
    // ========================================
    for (genvar b = 0; b < BIN_NUM; b++) begin : gLane
        coalescingUnit uCu (
            .clk_i           (clk_i),
            .rstN_i          (rstN_i),
            .initialFinish_i (initialFinish_i),
            .binSelected_i   (binSelected_i[b]),
            .cuIn_i          (cuIn_i[b]),
            .cuReady_o       (cuReady_o[b]),
            .searchReq_o     (searchReq[b]),
            .searchValue_i   (searchValue[b]),
            .cuClean_o       (cuClean_o[b])
        );

        eventBin #(.numRows(numRows)) uBin (
            .clk_i         (clk_i),
            .rstN_i        (rstN_i),
            .binSelected_i (binSelected_i[b]),
            .readEn_i      (readEn_i),
            .searchReq_i   (searchReq[b]),
            .searchValue_o (searchValue[b]),
            .binValid_o    (binValid_o[b]),
            .row_o         (binRow[b]),
            .rowReady_i    (binReady[b])
        );

        // Ready only reaches the granted bin
        assign binReady[b] = binSelected_i[b] & rowReady_i;
    end

    // Output mux, bin index filled in here
    always_comb begin
        rowOut_o = '0;
        for (int b = 0; b < BIN_NUM; b++) begin
            if (binSelected_i[b]) begin
                rowOut_o        = binRow[b];
                rowOut_o.binIdx = BIN_IDX_W'(b);
            end
        end
    end

    // Converged when all bins empty and all units idle
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            queueEmpty_o <= 1'b1;
        end else begin
            queueEmpty_o <= (binValid_o == '0) && (&cuClean_o);
        end
    end

endmodule

`default_nettype wire

// ==== design/queueScheduler.sv ====
// Round-robin bin scheduler
// Grant held until the granted bin runs empty
`default_nettype none

module queueScheduler
    import eventCfgPkg::*;
(
    input  wire logic               clk_i,
    input  wire logic               rstN_i,
    input  wire logic               drainEn_i,
    input  wire logic [BIN_NUM-1:0] binValid_i,
    input  wire logic [BIN_NUM-1:0] cuClean_i,
    output logic [BIN_NUM-1:0]      binSelected_o,
    output logic                    readEn_o
);

    logic [BIN_IDX_W-1:0] lastServed;
    logic [BIN_IDX_W-1:0] nextIdx;
    logic                 nextValid;

    // Search from the bin after the last served one
    always_comb begin
        int cand;
        nextValid = 1'b0;
        nextIdx   = lastServed;
        // Walk backwards so the nearest candidate is kept
        for (int off = BIN_NUM; off >= 1; off--) begin
            cand = (int'(lastServed) + off) % BIN_NUM;
            if (binValid_i[cand] && cuClean_i[cand]) begin
                nextValid = 1'b1;
                nextIdx   = BIN_IDX_W'(cand);
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            binSelected_o <= '0;
            readEn_o      <= 1'b0;
            // Start so that bin 0 comes first
            lastServed    <= BIN_IDX_W'(BIN_NUM - 1);
        end else if (binSelected_o != '0) begin
            // Release once the granted bin is empty
            if ((binSelected_o & binValid_i) == '0) begin
                binSelected_o <= '0;
                readEn_o      <= 1'b0;
            end
        end else if (drainEn_i && nextValid) begin
            binSelected_o          <= '0;
            binSelected_o[nextIdx] <= 1'b1;
            readEn_o               <= 1'b1;
            lastServed             <= nextIdx;
        end
    end

endmodule

`default_nettype wire

// ==== sources.f ====
design/eventCfgPkg.sv
design/eventIfPkg.sv
design/eventBin.sv
design/coalescingUnit.sv
design/queueScheduler.sv
design/eventQueues.sv
design/eventQueueTop.sv
verif/eventQueue_assert.sv
verif/eventQueueTb.sv

// ==== verif/eventPatterns.hex ====
// [79:76] type 1 event, 2 expected row, 3 initialFinish, 4 drain, 5 blocked event, 0 end
// [75:72] lane, bin or ready mode; [71:64] vertex, row or test id; [63:0] deltas col3..col0
30000000000000000000
10000000000000000011
10000000000000000022
100D0000000000000033
12450000000000000044
40010000000000000000
20000000000000000022
20030000000000330000
22010000000000440000
30000000000000000001
112B0000000000001000
112B0000000000000234
112B000000000000F000
137C0000000000000005
137D0000000000000007
137C0000000000000003
40020000000000000000
23070000000000070008
21020234000000000000
10180000000000000101
10040000000000000102
125F0000000000000103
13600000000000000104
40030000000000000000
22070103000000000000
23000000000000000104
20010000000000000102
20060000000000000101
1120000000000000AAAA
11270000000000005555
113E0000000000001234
12420000000000000F0F
41040000000000000000
2100000000000000AAAA
21015555000000000000
21070000123400000000
220000000F0F00000000
40050000000000000000
10000000000000000010
11210000000000000020
50090000000000000077
40060000000000000000
20000000000000000010
21000000000000200000
20020000000000770000
00000000000000000000

// ==== verif/eventQueueTb.sv ====
// Testbench for the event queue top level
// Pattern-driven events and drains, row checks, watchdog
`default_nettype none

module eventQueueTb
    import eventCfgPkg::*, eventIfPkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic clk_i, rstN_i, initialFinish, drainEn, rowReady, queueEmpty;
    eventS [BIN_NUM-1:0] cuIn;
    logic [BIN_NUM-1:0]  cuReady;
    rowS                 rowOut;

    logic [79:0] patMem [0:63];
    logic [79:0] expRows [$];
    logic [31:0] lcgState;
    int          errorCount, checkCount, testCount, patCount;
    // Blocked event, offered only while its bin drains
    logic        blkArmed;
    logic [79:0] blkWord;

    eventQueueTop #(.numRows(8)) dut (
        .clk_i(clk_i), .rstN_i(rstN_i), .initialFinish_i(initialFinish),
        .drainEn_i(drainEn), .cuIn_i(cuIn), .cuReady_o(cuReady),
        .rowOut_o(rowOut), .rowReady_i(rowReady), .queueEmpty_o(queueEmpty)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic string testName(input int id);
        case (id)
            1: return "initial overwrite";
            2: return "accumulate";
            3: return "drain order";
            4: return "back-pressure";
            5: return "clearing";
            6: return "blocking";
            default: return "unknown";
        endcase
    endfunction

    // Inputs change 2 ns after the edge
    task automatic tick();
        @(posedge clk_i);
        #2;
    endtask

    // Hold the event until the lane takes it
    task automatic sendEvent(input logic [79:0] w);
        logic taken;
        cuIn[w[73:72]].valid       = 1'b1;
        cuIn[w[73:72]].vertex.flat = w[70:64];
        cuIn[w[73:72]].delta       = w[15:0];
        taken = 1'b0;
        while (!taken) begin
            #28;
            taken = cuReady[w[73:72]];
            tick();
        end
        cuIn[w[73:72]].valid = 1'b0;
    endtask

    // ========================================
    // Drain and row checks
    // ========================================
    task automatic runDrain(input logic mode, input int id);
        int   rxIdx, quiet, stalls, errBefore;
        logic offering, blkDone;
        rxIdx = 0;
        quiet = 0;
        stalls = 0;
        offering = 1'b0;
        blkDone = !blkArmed;
        errBefore = errorCount;
        // Last accepted event lands in storage two edges later
        tick();
        tick();
        checkCount++;
        assert (queueEmpty == (expRows.size() == 0))
        else begin
            $display("CHECK FAILED %s: queueEmpty expected %0b actual %0b", testName(id),
                expRows.size() == 0, queueEmpty);
            errorCount++;
        end
        drainEn = 1'b1;
        while (quiet < 2) begin
            if (mode) begin
                lcgState = lcgNext(lcgState);
                rowReady = lcgState[16];
            end else begin
                rowReady = 1'b1;
            end
            if (offering) begin
                cuIn[blkWord[73:72]].valid       = 1'b1;
                cuIn[blkWord[73:72]].vertex.flat = blkWord[70:64];
                cuIn[blkWord[73:72]].delta       = blkWord[15:0];
            end
            #28;
            if (rowOut.valid && rowReady) begin
                if (rxIdx < expRows.size()) begin
                    checkCount++;
                    assert ({rowOut.binIdx, rowOut.rowIdx, rowOut.deltas} ==
                            {expRows[rxIdx][73:72], expRows[rxIdx][66:64], expRows[rxIdx][63:0]})
                    else begin
                        $display("CHECK FAILED %s: expected %h actual %h", testName(id),
                            {expRows[rxIdx][73:72], expRows[rxIdx][66:64], expRows[rxIdx][63:0]},
                            {rowOut.binIdx, rowOut.rowIdx, rowOut.deltas});
                        errorCount++;
                    end
                end else begin
                    $display("%s: row received beyond the expected rows", testName(id));
                    errorCount++;
                end
                rxIdx++;
            end
            if (offering) begin
                if (cuReady[blkWord[73:72]]) begin
                    offering = 1'b0;
                    blkDone = 1'b1;
                end else begin
                    stalls++;
                end
            end else if (!blkDone && !cuReady[blkWord[73:72]]) begin
                // Bin now granted, start offering
                offering = 1'b1;
            end
            quiet = (queueEmpty && blkDone) ? quiet + 1 : 0;
            tick();
            if (blkArmed && !offering) cuIn[blkWord[73:72]].valid = 1'b0;
        end
        drainEn = 1'b0;
        rowReady = 1'b0;
        checkCount++;
        assert (rxIdx == expRows.size())
        else begin
            $display("CHECK FAILED %s: expected %0d rows actual %0d rows", testName(id),
                expRows.size(), rxIdx);
            errorCount++;
        end
        if (blkArmed) begin
            checkCount++;
            assert (stalls > 0)
            else begin
                $display("%s: event was never held back by a selected bin", testName(id));
                errorCount++;
            end
        end
        blkArmed = 1'b0;
        testCount++;
        $display("test %0d %s: %0d rows, %s", id, testName(id), rxIdx,
            (errorCount == errBefore) ? "ok" : "errors");
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int idx;
        logic [79:0] w;
        rstN_i = 1'b0;
        initialFinish = 1'b0;
        drainEn = 1'b0;
        rowReady = 1'b0;
        cuIn = '0;
        blkArmed = 1'b0;
        blkWord = '0;
        lcgState = 32'd22;
        errorCount = 0;
        checkCount = 0;
        testCount = 0;
        for (int i = 0; i < 64; i++) patMem[i] = '0;
        $readmemh("verif/eventPatterns.hex", patMem);
        patCount = 0;
        for (int i = 0; i < 64; i++) if (patMem[i][79:76] != 4'h0) patCount++;
        repeat (10) @(posedge clk_i);
        #2;
        rstN_i = 1'b1;
        tick();
        idx = 0;
        while (idx < 64 && patMem[idx][79:76] != 4'h0) begin
            w = patMem[idx];
            idx++;
            case (w[79:76])
                4'h1: sendEvent(w);
                4'h3: initialFinish = w[0];
                4'h5: begin
                    blkArmed = 1'b1;
                    blkWord = w;
                end
                4'h4: begin
                    expRows.delete();
                    while (idx < 64 && patMem[idx][79:76] == 4'h2) begin
                        expRows.push_back(patMem[idx]);
                        idx++;
                    end
                    runDrain(w[72], int'(w[71:64]));
                end
                default: begin
                    $display("Pattern word %0d has an unknown type", idx - 1);
                    errorCount++;
                end
            endcase
        end
        $display("tests %0d, checks %0d, errors %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    // Watchdog, 40 cycles per pattern word plus margin
    initial begin
        #1;
        repeat (patCount * 40 + 400) @(posedge clk_i);
        $display("Watchdog timeout, a drain or event handshake never completed");
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/eventQueue_assert.sv ====
// Concurrent protocol assertions for the event queues
// Bound into eventQueues
`default_nettype none

module eventQueueAssert
    import eventCfgPkg::*, eventIfPkg::*;
(
    input wire logic                clk_i,
    input wire logic                rstN_i,
    input wire logic [BIN_NUM-1:0]  binSelected_i,
    input wire logic [BIN_NUM-1:0]  cuReady_o,
    input wire eventS [BIN_NUM-1:0] cuIn_i,
    input wire rowS                 rowOut_o,
    input wire logic                rowReady_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // At most one bin granted
    assert property (@(posedge clk_i) disable iff (!rstN_i) $onehot0(binSelected_i))
        else $error("binSelected is not one-hot or zero");

    // Offered row held while stalled
    assert property (@(posedge clk_i) disable iff (!rstN_i)
        rowOut_o.valid && !rowReady_i |=> $stable(rowOut_o))
        else $error("rowOut changed while waiting for ready");

    for (genvar k = 0; k < BIN_NUM; k++) begin : gLaneChk
        // Draining bin blocks its own lane
        assert property (@(posedge clk_i) disable iff (!rstN_i)
            binSelected_i[k] |-> !cuReady_o[k])
            else $error("lane %0d ready while its bin is selected", k);
        // Lane and bin field agree
        assert property (@(posedge clk_i) disable iff (!rstN_i)
            cuIn_i[k].valid |-> cuIn_i[k].vertex.fields.binIdx == BIN_IDX_W'(k))
            else $error("event on lane %0d addressed to another bin", k);
    end

endmodule

bind eventQueues eventQueueAssert uAssert (
    .clk_i         (clk_i),
    .rstN_i        (rstN_i),
    .binSelected_i (binSelected_i),
    .cuReady_o     (cuReady_o),
    .cuIn_i        (cuIn_i),
    .rowOut_o      (rowOut_o),
    .rowReady_i    (rowReady_i)
);

`default_nettype wire
